//--- Makefile
VERILATOR  ?= verilator
TOP        ?= mem_tb
LOG        ?= sim.log
SEED_FLAGS ?= +verilator+seed+1
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv source/*.svh test/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it, log to $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP LOG SEED_FLAGS OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): all.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f all.f

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SEED_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+source
source/mem_pkg.sv
source/dram_cmd_if.sv
source/req_capture.sv
source/dram_arbiter.sv
source/dram_bank.sv
source/mem_subsystem_top.sv
test/mem_assertions.sv
test/mem_checker.sv
test/mem_tb.sv

//--- source/dram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module dram_arbiter (
  input  logic              clk,
  input  logic              rst,

  // fetch request buffer
  input  logic              imem_pend,
  input  mem_pkg::imem_req_t imem_req,
  output logic              imem_take,

  // data request buffer
  input  logic              dmem_pend,
  input  mem_pkg::dmem_req_t dmem_req,
  output logic              dmem_take,

  // bank command bus
  dram_cmd_if.arbiter       dram,

  // responses
  output mem_pkg::word_t    imem_rdata,
  output logic              imem_rvalid,
  output mem_pkg::word_t    dmem_rdata,
  output logic              dmem_rvalid,
  output logic              dmem_written
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,  // fetch command in flight
    S_DATA    // data command in flight
  } state_t;

  state_t state;

  addr_t  cmd_addr;
  word_t  cmd_wdata;
  lanes_t cmd_we;
  logic   issue;
  logic   resp;

  // fetch wins when both are waiting
  assign imem_take = (state == S_IDLE) && imem_pend;
  assign dmem_take = (state == S_IDLE) && dmem_pend && !imem_pend;
  assign issue     = imem_take || dmem_take;
  assign resp      = dram.rvalid || dram.written;

  always_comb begin
    if (imem_take) begin
      cmd_addr  = imem_req.addr;
      cmd_wdata = '0;
      cmd_we    = '0;  // fetches always read
    end else begin
      cmd_addr  = dmem_req.addr;
      cmd_wdata = dmem_req.wdata;
      cmd_we    = dmem_req.we;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      dram.oe     <= 1'b0;
      imem_rvalid <= 1'b0;
      dmem_rvalid <= 1'b0;
    end else begin
      dram.oe     <= issue;
      imem_rvalid <= (state == S_FETCH) && dram.rvalid;
      dmem_rvalid <= (state == S_DATA) && dram.rvalid;
      case (state)
        S_IDLE: begin
          if (imem_take) begin
            state <= S_FETCH;
          end else if (dmem_take) begin
            state <= S_DATA;
          end
        end
        default: begin
          if (resp) begin
            state <= S_IDLE;  // free for a new grant next cycle
          end
        end
      endcase
    end
  end

  // command payload, qualified by oe
  always_ff @(posedge clk) begin
    if (issue) begin
      dram.addr  <= cmd_addr;
      dram.wdata <= cmd_wdata;
      dram.we    <= cmd_we;
    end
  end

  // read data goes to the owner only
  always_ff @(posedge clk) begin
    if (state == S_FETCH && dram.rvalid) begin
      imem_rdata <= dram.rdata;
    end
    if (state == S_DATA && dram.rvalid) begin
      dmem_rdata <= dram.rdata;
    end
  end

  assign dmem_written = dram.written;  // only data writes exist

endmodule

`default_nettype wire

//--- source/dram_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_settings.svh"

module dram_bank (
  input  logic     clk,
  input  logic     rst,
  dram_cmd_if.bank dram
);
  import mem_pkg::*;

  localparam int DEPTH  = 1 << `MEM_ADDR_W;
  localparam int LANES  = `MEM_LANES;
  localparam int LANE_W = `MEM_DATA_W / `MEM_LANES;
  localparam int LAT    = `DRAM_LATENCY;

  word_t mem [DEPTH];

  logic [LAT-1:0] rd_pipe;
  logic [LAT-1:0] wr_pipe;
  word_t          data_pipe [LAT];
  logic           is_write;

  // power-up contents are zero
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign is_write = |dram.we;

  always_ff @(posedge clk) begin
    if (dram.oe) begin
      for (int l = 0; l < LANES; l++) begin
        if (dram.we[l]) begin
          mem[dram.addr][l*LANE_W +: LANE_W] <= dram.wdata[l*LANE_W +: LANE_W];
        end
      end
      data_pipe[0] <= mem[dram.addr];  // whole word on read
    end
    for (int s = 1; s < LAT; s++) begin
      data_pipe[s] <= data_pipe[s-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pipe <= '0;
      wr_pipe <= '0;
    end else begin
      rd_pipe[0] <= dram.oe && !is_write;
      wr_pipe[0] <= dram.oe && is_write;
      for (int s = 1; s < LAT; s++) begin
        rd_pipe[s] <= rd_pipe[s-1];
        wr_pipe[s] <= wr_pipe[s-1];
      end
    end
  end

  assign dram.rvalid  = rd_pipe[LAT-1];
  assign dram.written = wr_pipe[LAT-1];
  assign dram.rdata   = data_pipe[LAT-1];

endmodule

`default_nettype wire

//--- source/dram_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dram_cmd_if;
  import mem_pkg::*;

  // command side, one-cycle oe pulse
  logic   oe;
  addr_t  addr;
  word_t  wdata;
  lanes_t we;      // nonzero with oe is a write

  // response side, no ready
  word_t  rdata;
  logic   rvalid;
  logic   written;

  modport arbiter (
    output oe, addr, wdata, we,
    input  rdata, rvalid, written
  );

  modport bank (
    input  oe, addr, wdata, we,
    output rdata, rvalid, written
  );

endinterface

`default_nettype wire

//--- source/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

  typedef logic [`MEM_DATA_W-1:0] word_t;
  typedef logic [`MEM_ADDR_W-1:0] addr_t;
  typedef logic [`MEM_LANES-1:0]  lanes_t;  // one bit per byte lane

  // instruction fetch, read only
  typedef struct packed {
    addr_t addr;
  } imem_req_t;

  // data load/store; we == 0 means read
  typedef struct packed {
    addr_t  addr;
    word_t  wdata;
    lanes_t we;
  } dmem_req_t;

endpackage

//--- source/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// word address width, 1024 words
`define MEM_ADDR_W 10

// data word width
`define MEM_DATA_W 32

// byte lanes per word
`define MEM_LANES 4

// cycles from bank command to its response pulse
`define DRAM_LATENCY 3

`endif

//--- source/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
  input  logic            clk,
  input  logic            rst,

  // instruction fetch port
  input  logic            imem_req_valid,
  output logic            imem_req_ready,
  input  mem_pkg::addr_t  imem_addr,
  output mem_pkg::word_t  imem_rdata,
  output logic            imem_rvalid,

  // data load/store port
  input  logic            dmem_req_valid,
  output logic            dmem_req_ready,
  input  mem_pkg::addr_t  dmem_addr,
  input  mem_pkg::word_t  dmem_wdata,
  input  mem_pkg::lanes_t dmem_we,
  output mem_pkg::word_t  dmem_rdata,
  output logic            dmem_rvalid,
  output logic            dmem_written
);
  import mem_pkg::*;

  imem_req_t imem_in;
  imem_req_t imem_pend_req;
  dmem_req_t dmem_in;
  dmem_req_t dmem_pend_req;
  logic      imem_pend;
  logic      imem_take;
  logic      dmem_pend;
  logic      dmem_take;

  dram_cmd_if dram_bus ();

  assign imem_in = '{addr: imem_addr};
  assign dmem_in = '{addr: dmem_addr, wdata: dmem_wdata, we: dmem_we};

  req_capture #(.payload_t(imem_req_t)) imem_cap_i (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (imem_req_valid),
    .in_ready     (imem_req_ready),
    .in_payload   (imem_in),
    .pend_valid   (imem_pend),
    .pend_payload (imem_pend_req),
    .take         (imem_take)
  );

  req_capture #(.payload_t(dmem_req_t)) dmem_cap_i (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (dmem_req_valid),
    .in_ready     (dmem_req_ready),
    .in_payload   (dmem_in),
    .pend_valid   (dmem_pend),
    .pend_payload (dmem_pend_req),
    .take         (dmem_take)
  );

  dram_arbiter arb_i (
    .clk          (clk),
    .rst          (rst),
    .imem_pend    (imem_pend),
    .imem_req     (imem_pend_req),
    .imem_take    (imem_take),
    .dmem_pend    (dmem_pend),
    .dmem_req     (dmem_pend_req),
    .dmem_take    (dmem_take),
    .dram         (dram_bus.arbiter),
    .imem_rdata   (imem_rdata),
    .imem_rvalid  (imem_rvalid),
    .dmem_rdata   (dmem_rdata),
    .dmem_rvalid  (dmem_rvalid),
    .dmem_written (dmem_written)
  );

  dram_bank bank_i (
    .clk  (clk),
    .rst  (rst),
    .dram (dram_bus.bank)
  );

endmodule

`default_nettype wire

//--- source/req_capture.sv
`timescale 1ns/1ps
`default_nettype none

module req_capture #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,

  // requester side
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_payload,

  // arbiter side
  output logic     pend_valid,
  output payload_t pend_payload,
  input  logic     take
);

  logic accept;

  assign in_ready = !pend_valid;  // only when empty
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_valid <= 1'b0;
    end else if (accept) begin
      pend_valid <= 1'b1;
    end else if (take) begin
      pend_valid <= 1'b0;  // free again next cycle
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pend_payload <= in_payload;
    end
  end

endmodule

`default_nettype wire

//--- test/mem_assertions.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_assertions (
  input logic clk,
  input logic rst,
  input logic oe,
  input logic resp,
  input logic imem_take,
  input logic dmem_take,
  input logic imem_rvalid,
  input logic dmem_rvalid
);

  int age;  // cycles since oe, 0 when the bank is free

  always @(posedge clk) begin
    if (rst || resp) begin
      age <= 0;
    end else if (oe || age != 0) begin
      age <= age + 1;
    end
  end

  one_cmd: assert property (@(posedge clk) disable iff (rst) oe |-> age == 0)
    else $error("bank command issued while another is in flight");

  one_take: assert property (@(posedge clk) disable iff (rst) !(imem_take && dmem_take))
    else $error("both request buffers taken in the same cycle");

  one_rvalid: assert property (@(posedge clk) disable iff (rst) !(imem_rvalid && dmem_rvalid))
    else $error("fetch and load read data returned in the same cycle");

  resp_in_time: assert property (@(posedge clk) disable iff (rst) age <= `DRAM_LATENCY + 1)
    else $error("bank response missing after a command");

endmodule

bind dram_arbiter mem_assertions assert_i (
  .clk         (clk),
  .rst         (rst),
  .oe          (dram.oe),
  .resp        (dram.rvalid || dram.written),
  .imem_take   (imem_take),
  .dmem_take   (dmem_take),
  .imem_rvalid (imem_rvalid),
  .dmem_rvalid (dmem_rvalid)
);

//--- test/mem_checker.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_checker (
  input  logic            clk, rst,
  input  logic            imem_req_valid, imem_req_ready, imem_rvalid,
  input  mem_pkg::addr_t  imem_addr, dmem_addr,
  input  mem_pkg::word_t  imem_rdata, dmem_wdata, dmem_rdata,
  input  logic            dmem_req_valid, dmem_req_ready, dmem_rvalid, dmem_written,
  input  mem_pkg::lanes_t dmem_we,
  input  logic            test_end, report,
  input  int              test_num,
  output int              errors, pending
);
  import mem_pkg::*;

  localparam int LANE_W = `MEM_DATA_W / `MEM_LANES;

  word_t     ref_mem [1 << `MEM_ADDR_W];
  addr_t     imem_q [$];
  dmem_req_t dmem_q [$];
  int        imem_stamp [$];  // acceptance cycle per request
  int        dmem_stamp [$];
  dmem_req_t d_req;
  int        cycle, rst_edges, checks, fails, all_checks;

  function automatic word_t lane_merge(input word_t old, input word_t data, input lanes_t mask);
    word_t res;
    res = old;
    for (int l = 0; l < `MEM_LANES; l++) begin
      if (mask[l]) begin
        res[l*LANE_W +: LANE_W] = data[l*LANE_W +: LANE_W];
      end
    end
    return res;
  endfunction

  task automatic note_fail(input string msg);
    fails++;
    errors++;
    $display("%s (at %0t)", msg, $time);
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    all_checks++;
    if (got !== exp) begin
      fails++;
      errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // the bank runs one command at a time, so responses come in bank order
  always @(posedge clk) begin
    cycle++;
    if (rst) begin
      if (rst_edges > 0) begin  // outputs settle after the first reset edge
        check_word("ready/valid outputs in reset", word_t'({imem_req_ready, dmem_req_ready,
                   imem_rvalid, dmem_rvalid, dmem_written}), word_t'(5'b11000));
      end
      rst_edges++;
      imem_q.delete();
      dmem_q.delete();
      imem_stamp.delete();
      dmem_stamp.delete();
      for (int i = 0; i < (1 << `MEM_ADDR_W); i++) begin
        ref_mem[i] = '0;
      end
    end else begin
      if (imem_rvalid) begin
        if (imem_q.size() == 0) begin
          note_fail("fetch read data arrived with no fetch request outstanding");
        end else begin
          check_word($sformatf("fetch of %h", imem_q[0]), imem_rdata, ref_mem[imem_q[0]]);
          void'(imem_q.pop_front());
          void'(imem_stamp.pop_front());
        end
      end
      if (dmem_rvalid || dmem_written) begin
        if (dmem_q.size() == 0) begin
          note_fail("data response arrived with no data request outstanding");
        end else begin
          d_req = dmem_q.pop_front();
          if (imem_stamp.size() > 0 && imem_stamp[0] <= dmem_stamp[0]) begin
            note_fail("data request answered ahead of a fetch accepted no later");
          end
          void'(dmem_stamp.pop_front());
          if (dmem_written != (d_req.we != '0)) begin
            note_fail("data response type does not match its request");
          end else if (dmem_rvalid) begin
            check_word($sformatf("load of %h", d_req.addr), dmem_rdata, ref_mem[d_req.addr]);
          end else begin
            ref_mem[d_req.addr] = lane_merge(ref_mem[d_req.addr], d_req.wdata, d_req.we);
          end
        end
      end
      if (imem_req_valid && imem_req_ready) begin
        imem_q.push_back(imem_addr);
        imem_stamp.push_back(cycle);
      end
      if (dmem_req_valid && dmem_req_ready) begin
        d_req = '{addr: dmem_addr, wdata: dmem_wdata, we: dmem_we};
        dmem_q.push_back(d_req);
        dmem_stamp.push_back(cycle);
      end
    end
    pending = imem_q.size() + dmem_q.size();
    if (test_end) begin
      $display("test %0d finished: %0d checks, %0d failed", test_num, checks, fails);
      checks = 0;
      fails  = 0;
    end
    if (report) begin
      $display("totals: %0d checks, %0d failed, %0d outstanding", all_checks, errors, pending);
    end
  end

endmodule

//--- test/mem_tb.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_tb;
  import mem_pkg::*;

  typedef struct {
    int     test;
    logic   f_valid;
    addr_t  f_addr;
    logic   d_valid;
    addr_t  d_addr;
    word_t  d_data;
    lanes_t d_mask;  // all zero is a load
    int     gap;     // idle cycles after acceptance
  } stim_t;

  logic        clk, rst, test_end, report;
  logic        imem_req_valid, imem_req_ready, imem_rvalid;
  logic        dmem_req_valid, dmem_req_ready, dmem_rvalid, dmem_written;
  addr_t       imem_addr, dmem_addr;
  word_t       imem_rdata, dmem_wdata, dmem_rdata;
  lanes_t      dmem_we;
  int          test_num, errors, pending, cycles, limit;
  stim_t       stim_q [$];
  logic [31:0] rng, r;

  mem_subsystem_top dut_i (.*);
  mem_checker checker_i (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic void add_entry(input int test, input logic fv, input addr_t fa,
                                    input logic dv, input addr_t da, input word_t dd,
                                    input lanes_t dm, input int gap);
    stim_t s;
    s = '{test, fv, fa, dv, da, dd, dm, gap};
    stim_q.push_back(s);
  endfunction

  // holds each valid until its port accepts, starting 1 ns after an edge
  task automatic apply_entry(input stim_t s);
    logic f_wait, d_wait, f_hit, d_hit;
    f_wait     = s.f_valid;
    d_wait     = s.d_valid;
    imem_addr  = s.f_addr;
    dmem_addr  = s.d_addr;
    dmem_wdata = s.d_data;
    dmem_we    = s.d_mask;
    while (f_wait || d_wait) begin
      imem_req_valid = f_wait;
      dmem_req_valid = d_wait;
      f_hit = f_wait && imem_req_ready;  // ready only moves on an edge
      d_hit = d_wait && dmem_req_ready;
      @(posedge clk);
      #1;
      f_wait = f_wait && !f_hit;
      d_wait = d_wait && !d_hit;
    end
    imem_req_valid = 1'b0;
    dmem_req_valid = 1'b0;
    repeat (s.gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finish_test(input int num);
    while (pending != 0) begin
      @(posedge clk);
      #1;
    end
    test_num = num;
    test_end = 1'b1;
    @(posedge clk);
    #1;
    test_end = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("run timed out after %0d cycles, %0d responses outstanding", cycles, pending);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    rst            = 1'b1;
    imem_req_valid = 1'b0;
    imem_addr      = '0;
    dmem_req_valid = 1'b0;
    dmem_addr      = '0;
    dmem_wdata     = '0;
    dmem_we        = '0;
    test_end       = 1'b0;
    report         = 1'b0;
    test_num       = 0;
    add_entry(1, 1'b0, 10'h000, 1'b1, 10'h010, 32'hdeadbeef, 4'b1111, 0);
    add_entry(1, 1'b0, 10'h000, 1'b1, 10'h010, 32'h00000000, 4'b0000, 2);
    add_entry(2, 1'b0, 10'h000, 1'b1, 10'h020, 32'haabbccdd, 4'b0001, 0);
    add_entry(2, 1'b0, 10'h000, 1'b1, 10'h020, 32'h55667788, 4'b0100, 0);
    add_entry(2, 1'b0, 10'h000, 1'b1, 10'h020, 32'h99000011, 4'b1010, 0);
    add_entry(2, 1'b0, 10'h000, 1'b1, 10'h020, 32'h00000000, 4'b0000, 2);
    add_entry(3, 1'b1, 10'h010, 1'b0, 10'h000, 32'h00000000, 4'b0000, 0);
    add_entry(3, 1'b1, 10'h020, 1'b0, 10'h000, 32'h00000000, 4'b0000, 0);
    add_entry(3, 1'b1, 10'h3ff, 1'b0, 10'h000, 32'h00000000, 4'b0000, 1);  // never written
    add_entry(4, 1'b1, 10'h020, 1'b1, 10'h020, 32'hcafef00d, 4'b1111, 0);
    add_entry(4, 1'b1, 10'h010, 1'b1, 10'h020, 32'h00000000, 4'b0000, 2);
    add_entry(5, 1'b1, 10'h030, 1'b0, 10'h000, 32'h00000000, 4'b0000, 0);
    add_entry(5, 1'b0, 10'h000, 1'b1, 10'h020, 32'h00000000, 4'b0000, 0);
    add_entry(5, 1'b0, 10'h000, 1'b1, 10'h030, 32'h01020304, 4'b1111, 0);  // buffer full
    add_entry(5, 1'b1, 10'h030, 1'b1, 10'h030, 32'h00000000, 4'b0000, 2);
    rng = 32'h6520d008;
    for (int i = 0; i < 40; i++) begin
      rng = xorshift(rng);
      r   = rng;
      rng = xorshift(rng);
      add_entry(6, r[0], addr_t'(10'h010 + {5'd0, r[8:4]}), r[1] || !r[0],
                addr_t'(10'h010 + {5'd0, r[13:9]}), rng, r[14] ? r[18:15] : 4'b0000,
                int'(r[20:19]) % 3);
    end
    limit = stim_q.size() * 2 * (`DRAM_LATENCY + 4) + 100;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (stim_q[i]) begin
      if (i > 0 && stim_q[i].test != stim_q[i-1].test) begin
        finish_test(stim_q[i-1].test);
      end
      apply_entry(stim_q[i]);
    end
    finish_test(stim_q[stim_q.size()-1].test);
    report = 1'b1;
    @(posedge clk);
    #1;
    report = 1'b0;
    if (errors == 0 && pending == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
